/* src.f */
hdl/fmcadc5_sync_pkg.sv
hdl/fmcadc5_sync_regs.sv
hdl/fmcadc5_sysref_gen.sv
hdl/fmcadc5_sync_ctrl.sv
hdl/fmcadc5_aux_clk_gen.sv
hdl/fmcadc5_sync_top.sv
tb/fmcadc5_sync_sva.sv
tb/tb_fmcadc5_sync.sv

/* tb/tb_fmcadc5_sync.sv */
// fmcadc5 sync helper testbench: register traffic, sync, sysref and aux clock checks

`timescale 1ns/1ps

module tb_fmcadc5_sync;

  localparam logic [31:0] TB_CORE_ID = 32'h0000_0a5c;
  localparam int SEL_EXT  = 0;
  localparam int SEL_INT  = 1;
  localparam int SEL_VCAL = 2;

  logic                       rx_clk;
  logic                       up_rstn;
  fmcadc5_sync_pkg::reg_req_t reg_req;
  fmcadc5_sync_pkg::reg_rsp_t reg_rsp;
  logic [1:0]                 sync_in;
  logic [1:0]                 sync_out;
  logic                       sysref_ext;
  logic                       sysref_int;
  logic                       vcal;
  logic                       psync;
  integer                     seed;
  int                         checks;
  int                         errors;
  int                         timeouts;

  fmcadc5_sync_top #(
    .CORE_ID (TB_CORE_ID)
  ) dut0 (
    .rx_clk       (rx_clk),
    .up_rstn      (up_rstn),
    .reg_req_i    (reg_req),
    .reg_rsp_o    (reg_rsp),
    .sync_in_i    (sync_in),
    .sync_out_o   (sync_out),
    .sysref_ext_o (sysref_ext),
    .sysref_int_o (sysref_int),
    .vcal_o       (vcal),
    .psync_o      (psync)
  );

  initial begin
    rx_clk = 1'b0;
    forever #5 rx_clk = ~rx_clk;
  end

  // **********************************************************************
  // helpers
  // **********************************************************************

  // inputs change 1 ns after the edge, outputs are sampled there too
  task automatic next_cycle();
    @(posedge rx_clk);
    #1;
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAIL %s: expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    timeouts++;
  endtask

  task automatic reg_write(input logic [13:0] addr, input logic [31:0] data);
    int n;
    reg_req.wr    = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    next_cycle();
    reg_req.wr    = 1'b0;
    reg_req.wdata = '0;
    n = 1;
    while (!reg_rsp.ack && n < 8) begin
      next_cycle();
      n++;
    end
    if (!reg_rsp.ack) begin
      report_timeout("register write ack");
    end else begin
      check_eq("write ack latency", 1, n);
      check_eq("write ack rdata", 0, reg_rsp.rdata);
    end
  endtask

  task automatic reg_read(input logic [13:0] addr, output logic [31:0] data);
    int n;
    reg_req.rd   = 1'b1;
    reg_req.addr = addr;
    next_cycle();
    reg_req.rd = 1'b0;
    n = 1;
    while (!reg_rsp.ack && n < 8) begin
      next_cycle();
      n++;
    end
    if (!reg_rsp.ack) report_timeout("register read ack");
    else check_eq("read ack latency", 1, n);
    data = reg_rsp.rdata;
  endtask

  function automatic logic sig_level(input int sel);
    case (sel)
      SEL_EXT: return sysref_ext;
      SEL_INT: return sysref_int;
      default: return vcal;
    endcase
  endfunction

  // cycles counts the edges until the level shows up
  task automatic wait_level(input int sel, input logic level, input int limit,
                            input string what, output int cycles);
    cycles = 0;
    while (sig_level(sel) !== level && cycles < limit) begin
      next_cycle();
      cycles++;
    end
    if (sig_level(sel) !== level) report_timeout(what);
  endtask

  task automatic measure_runs(input int sel, input string name, input int exp_hi,
                              input int exp_lo, input int nruns);
    int hi;
    int lo;
    int skip;
    wait_level(sel, 1'b0, 600, {name, " low"}, skip);
    wait_level(sel, 1'b1, 600, {name, " rise"}, skip);
    for (int i = 0; i < nruns; i++) begin
      wait_level(sel, 1'b0, 600, {name, " fall"}, hi);
      check_eq({name, " high run"}, exp_hi, hi);
      wait_level(sel, 1'b1, 600, {name, " rise"}, lo);
      check_eq({name, " low run"}, exp_lo, lo);
    end
  endtask

  task automatic count_high(input int ncycles, output int ext_hi, output int int_hi);
    ext_hi = 0;
    int_hi = 0;
    repeat (ncycles) begin
      next_cycle();
      ext_hi += sysref_ext;
      int_hi += sysref_int;
    end
  endtask

  // reference for the sync lanes, cfg is {and_mode, disable_1, disable_0}
  function automatic logic [1:0] predict_sync(input logic [1:0] in, input logic [2:0] cfg);
    logic [1:0] src;
    src = cfg[2] ? {2{in[0] & in[1]}} : in;
    return src & ~cfg[1:0];
  endfunction

  // **********************************************************************
  // test sequences
  // **********************************************************************

  task automatic register_file_test();
    logic [31:0] rdata;
    logic [31:0] wdata;
    logic [31:0] mask;
    logic [31:0] load;
    logic [13:0] addr;
    int          sel;
    int          gap;
    reg_read(fmcadc5_sync_pkg::ADDR_VERSION, rdata);
    check_eq("version", fmcadc5_sync_pkg::CORE_VERSION, rdata);
    reg_read(fmcadc5_sync_pkg::ADDR_ID, rdata);
    check_eq("core id", TB_CORE_ID, rdata);
    for (int i = 0; i < 40; i++) begin
      sel   = $unsigned($random(seed)) % 5;
      wdata = $random(seed);
      case (sel)
        0: begin
          addr = fmcadc5_sync_pkg::ADDR_SCRATCH;
          mask = 32'hffff_ffff;
        end
        1: begin
          addr = fmcadc5_sync_pkg::ADDR_SYNC_CTRL;
          mask = 32'h0000_0007;
        end
        2: begin
          addr = fmcadc5_sync_pkg::ADDR_SYSREF_CTRL;
          mask = 32'h0000_0031;
        end
        3: begin
          addr = fmcadc5_sync_pkg::ADDR_VCAL_CNT;
          mask = 32'h0000_00ff;
        end
        default: begin
          addr = fmcadc5_sync_pkg::ADDR_VCAL_EN;
          mask = 32'h0000_0001;
        end
      endcase
      reg_write(addr, wdata);
      reg_read(addr, rdata);
      check_eq("register readback", wdata & mask, rdata);
    end
    // bit 8 set keeps the address outside the map
    for (int i = 0; i < 20; i++) begin
      addr = $random(seed);
      addr = addr | 14'h0100;
      reg_read(addr, rdata);
      check_eq("unmapped read", 0, rdata);
    end
    // timer loads at the write edge and drops by one per later edge
    for (int i = 0; i < 10; i++) begin
      load = $unsigned($random(seed)) % 64;
      gap  = $unsigned($random(seed)) % 48;
      reg_write(fmcadc5_sync_pkg::ADDR_TIMER, load);
      repeat (gap) next_cycle();
      reg_read(fmcadc5_sync_pkg::ADDR_TIMER, rdata);
      check_eq("timer countdown", (load > gap) ? load - gap : 0, rdata);
    end
  endtask

  task automatic sync_combine_test();
    logic [2:0] cfg;
    for (int i = 0; i < 8; i++) begin
      cfg = $random(seed);
      reg_write(fmcadc5_sync_pkg::ADDR_SYNC_CTRL, {29'd0, cfg});
      for (int j = 0; j < 25; j++) begin
        sync_in = $random(seed);
        next_cycle();
        check_eq("sync combine", predict_sync(sync_in, cfg), sync_out);
      end
    end
  endtask

  task automatic sync_status_test();
    logic [31:0] rdata;
    logic [1:0]  lvl;
    for (int i = 0; i < 6; i++) begin
      if (i < 4) lvl = i;
      else lvl = $random(seed);
      sync_in = lvl;
      repeat (600) next_cycle();
      reg_read(fmcadc5_sync_pkg::ADDR_SYNC_STATUS, rdata);
      check_eq("sync status", lvl, rdata);
    end
  endtask

  task automatic sysref_test();
    logic [31:0] rdata;
    logic        prev;
    int          ext_hi;
    int          int_hi;
    int          rises;
    int          n;
    reg_write(fmcadc5_sync_pkg::ADDR_SYSREF_CTRL, 32'h00);
    measure_runs(SEL_EXT, "sysref ext cont", 128, 128, 2);
    measure_runs(SEL_INT, "sysref int cont", 128, 128, 2);
    // both off, one window to settle
    reg_write(fmcadc5_sync_pkg::ADDR_SYSREF_CTRL, 32'h11);
    repeat (300) next_cycle();
    count_high(600, ext_hi, int_hi);
    check_eq("sysref ext off", 0, ext_hi);
    check_eq("sysref int off", 0, int_hi);
    // external one-shot, internal off
    reg_write(fmcadc5_sync_pkg::ADDR_SYSREF_CTRL, 32'h21);
    repeat (300) next_cycle();
    count_high(600, ext_hi, int_hi);
    check_eq("sysref one-shot without request", 0, ext_hi);
    check_eq("sysref int in one-shot", 0, int_hi);
    reg_read(fmcadc5_sync_pkg::ADDR_SYSREF_REQ, rdata);
    check_eq("sysref status idle", 0, rdata);
    reg_write(fmcadc5_sync_pkg::ADDR_SYSREF_REQ, 32'h1);
    rises  = 0;
    ext_hi = 0;
    n      = 0;
    prev   = sysref_ext;
    rdata  = 32'h1;
    // poll status every cycle while watching the pulse
    while (rdata[0] && n < 1200) begin
      reg_read(fmcadc5_sync_pkg::ADDR_SYSREF_REQ, rdata);
      if (n == 0) check_eq("sysref status set", 1, rdata);
      if (sysref_ext && !prev) rises++;
      ext_hi += sysref_ext;
      prev = sysref_ext;
      n++;
    end
    if (rdata[0]) report_timeout("sysref one-shot status to clear");
    check_eq("sysref one-shot pulses", 1, rises);
    check_eq("sysref one-shot high cycles", 128, ext_hi);
    count_high(600, ext_hi, int_hi);
    check_eq("sysref after one-shot", 0, ext_hi);
    reg_write(fmcadc5_sync_pkg::ADDR_SYSREF_CTRL, 32'h00);
  endtask

  task automatic vcal_test();
    logic [7:0] cnt;
    int         skip;
    int         hi;
    for (int i = 0; i < 3; i++) begin
      cnt = $unsigned($random(seed)) % 40;
      reg_write(fmcadc5_sync_pkg::ADDR_VCAL_CNT, {24'd0, cnt});
      reg_write(fmcadc5_sync_pkg::ADDR_VCAL_EN, 32'h1);
      measure_runs(SEL_VCAL, "vcal", cnt + 1, cnt + 1, 3);
      reg_write(fmcadc5_sync_pkg::ADDR_VCAL_EN, 32'h0);
      wait_level(SEL_VCAL, 1'b0, 600, "vcal to stop", skip);
      hi = 0;
      repeat (300) begin
        next_cycle();
        hi += vcal;
      end
      check_eq("vcal after disable", 0, hi);
    end
  endtask

  // any 20 frame span holds exactly 80 toggles
  task automatic psync_test();
    logic prev;
    int   toggles;
    prev    = psync;
    toggles = 0;
    repeat (83 * 20) begin
      next_cycle();
      if (psync !== prev) toggles++;
      prev = psync;
    end
    check_eq("psync toggles", 80, toggles);
  endtask

  // **********************************************************************
  // main sequence
  // **********************************************************************

  initial begin
    seed     = 32'hde19;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    up_rstn  = 1'b0;
    reg_req  = '0;
    sync_in  = 2'b00;
    repeat (4) @(posedge rx_clk);
    #1;
    up_rstn = 1'b1;
    check_eq("outputs after reset", 0,
             {sysref_ext, sysref_int, vcal, psync, sync_out, reg_rsp.ack});
    register_file_test();
    sync_combine_test();
    sync_status_test();
    sysref_test();
    vcal_test();
    psync_test();
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, dut0.sva0.fail_count, timeouts);
    if (errors == 0 && timeouts == 0 && dut0.sva0.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #2_000_000;
    $display("watchdog expired before the test sequence finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* tb/fmcadc5_sync_sva.sv */
// fmcadc5 sync helper assertions: register port handshake and disabled sync lanes

`timescale 1ns/1ps

module fmcadc5_sync_sva (
  input logic                        rx_clk,
  input logic                        up_rstn,
  input fmcadc5_sync_pkg::reg_req_t  reg_req_i,
  input fmcadc5_sync_pkg::reg_rsp_t  reg_rsp_i,
  input fmcadc5_sync_pkg::sync_cfg_t sync_cfg_i,
  input logic [1:0]                  sync_out_i
);

  int fail_count = 0;

  // ack exactly one cycle behind each strobe
  a_ack_after_strobe: assert property (@(posedge rx_clk) disable iff (!up_rstn)
    (reg_req_i.wr || reg_req_i.rd) |=> reg_rsp_i.ack)
    else begin
      $error("register ack missing one cycle after a strobe");
      fail_count++;
    end

  a_no_ack_without_strobe: assert property (@(posedge rx_clk) disable iff (!up_rstn)
    !(reg_req_i.wr || reg_req_i.rd) |=> !reg_rsp_i.ack)
    else begin
      $error("register ack without a strobe");
      fail_count++;
    end

  a_rdata_zero_without_ack: assert property (@(posedge rx_clk) disable iff (!up_rstn)
    !reg_rsp_i.ack |-> (reg_rsp_i.rdata == '0))
    else begin
      $error("register read data nonzero without ack");
      fail_count++;
    end

  // disabled lanes
  a_lane0_disabled: assert property (@(posedge rx_clk) disable iff (!up_rstn)
    sync_cfg_i.disable_0 |=> !sync_out_i[0])
    else begin
      $error("sync lane 0 high while disabled");
      fail_count++;
    end

  a_lane1_disabled: assert property (@(posedge rx_clk) disable iff (!up_rstn)
    sync_cfg_i.disable_1 |=> !sync_out_i[1])
    else begin
      $error("sync lane 1 high while disabled");
      fail_count++;
    end

endmodule

bind fmcadc5_sync_top fmcadc5_sync_sva sva0 (
  .rx_clk     (rx_clk),
  .up_rstn    (up_rstn),
  .reg_req_i  (reg_req_i),
  .reg_rsp_i  (reg_rsp_o),
  .sync_cfg_i (sync_cfg),
  .sync_out_i (sync_out_o)
);

/* hdl/fmcadc5_sync_top.sv */
// fmcadc5 sync helper top level: register file and the sysref, sync and aux clock blocks

`timescale 1ns/1ps

module fmcadc5_sync_top #(
  parameter logic [fmcadc5_sync_pkg::DATA_W-1:0] CORE_ID = '0
) (
  input  logic                       rx_clk,
  input  logic                       up_rstn,
  input  fmcadc5_sync_pkg::reg_req_t reg_req_i,
  output fmcadc5_sync_pkg::reg_rsp_t reg_rsp_o,
  input  logic [1:0]                 sync_in_i,
  output logic [1:0]                 sync_out_o,
  output logic                       sysref_ext_o,
  output logic                       sysref_int_o,
  output logic                       vcal_o,
  output logic                       psync_o
);

  fmcadc5_sync_pkg::sync_cfg_t         sync_cfg;
  fmcadc5_sync_pkg::sysref_cfg_t       sysref_cfg;
  logic [1:0]                          sync_status;
  logic                                sysref_req;
  logic                                sysref_ack;
  logic [fmcadc5_sync_pkg::VCAL_W-1:0] vcal_cnt;
  logic                                vcal_en;

  fmcadc5_sync_regs #(
    .CORE_ID (CORE_ID)
  ) i_regs (
    .rx_clk        (rx_clk),
    .up_rstn       (up_rstn),
    .reg_req_i     (reg_req_i),
    .reg_rsp_o     (reg_rsp_o),
    .sync_cfg_o    (sync_cfg),
    .sync_status_i (sync_status),
    .sysref_cfg_o  (sysref_cfg),
    .sysref_req_o  (sysref_req),
    .sysref_ack_i  (sysref_ack),
    .vcal_cnt_o    (vcal_cnt),
    .vcal_en_o     (vcal_en)
  );

  fmcadc5_sysref_gen i_sysref_gen (
    .rx_clk       (rx_clk),
    .up_rstn      (up_rstn),
    .sysref_cfg_i (sysref_cfg),
    .sysref_req_i (sysref_req),
    .sysref_ack_o (sysref_ack),
    .sysref_ext_o (sysref_ext_o),
    .sysref_int_o (sysref_int_o)
  );

  fmcadc5_sync_ctrl i_sync_ctrl (
    .rx_clk        (rx_clk),
    .up_rstn       (up_rstn),
    .sync_cfg_i    (sync_cfg),
    .sync_in_i     (sync_in_i),
    .sync_out_o    (sync_out_o),
    .sync_status_o (sync_status)
  );

  fmcadc5_aux_clk_gen i_aux_clk_gen (
    .rx_clk     (rx_clk),
    .up_rstn    (up_rstn),
    .vcal_cnt_i (vcal_cnt),
    .vcal_en_i  (vcal_en),
    .vcal_o     (vcal_o),
    .psync_o    (psync_o)
  );

endmodule

/* hdl/fmcadc5_aux_clk_gen.sv */
// fmcadc5 auxiliary clocks: programmable vcal square wave and fixed psync regulator clock

`timescale 1ns/1ps

module fmcadc5_aux_clk_gen (
  input  logic                                rx_clk,
  input  logic                                up_rstn,
  input  logic [fmcadc5_sync_pkg::VCAL_W-1:0] vcal_cnt_i,
  input  logic                                vcal_en_i,
  output logic                                vcal_o,
  output logic                                psync_o
);

  logic [fmcadc5_sync_pkg::VCAL_W-1:0] vcal_div;
  logic [7:0]                          psync_cnt;

  // vcal half period is vcal_cnt+1 cycles
  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      vcal_div <= '0;
      vcal_o   <= 1'b0;
    end else if (vcal_div >= vcal_cnt_i) begin
      vcal_div <= '0;
      // disable takes effect at the terminal count
      vcal_o   <= ~vcal_o & vcal_en_i;
    end else begin
      vcal_div <= vcal_div + 1'b1;
    end
  end

  // **********************************************************************
  // regulator clock
  // **********************************************************************

  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      psync_cnt <= '0;
      psync_o   <= 1'b0;
    end else begin
      if (psync_cnt >= fmcadc5_sync_pkg::PSYNC_LAST) begin
        psync_cnt <= '0;
      end else begin
        psync_cnt <= psync_cnt + 1'b1;
      end
      if (psync_cnt >= fmcadc5_sync_pkg::PSYNC_TOGGLE) begin
        psync_o <= ~psync_o;
      end
    end
  end

endmodule

/* hdl/fmcadc5_sync_ctrl.sv */
// fmcadc5 sync combiner: per-lane disable, optional and mode, windowed level status

`timescale 1ns/1ps

module fmcadc5_sync_ctrl (
  input  logic                        rx_clk,
  input  logic                        up_rstn,
  input  fmcadc5_sync_pkg::sync_cfg_t sync_cfg_i,
  input  logic [1:0]                  sync_in_i,
  output logic [1:0]                  sync_out_o,
  output logic [1:0]                  sync_status_o
);

  localparam int PW = fmcadc5_sync_pkg::PERIOD_W;

  logic [PW-1:0] win_cnt;
  logic          win_start;
  logic [1:0]    lane_src;
  logic [1:0]    lane_dis;
  logic [1:0]    hold;

  // **********************************************************************
  // combining
  // **********************************************************************

  assign lane_src = sync_cfg_i.and_mode ? {2{&sync_in_i}} : sync_in_i;
  assign lane_dis = {sync_cfg_i.disable_1, sync_cfg_i.disable_0};

  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      sync_out_o <= '0;
    end else begin
      sync_out_o <= lane_src & ~lane_dis;
    end
  end

  // **********************************************************************
  // status window
  // **********************************************************************

  assign win_start = (win_cnt == '0);

  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      win_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
    end
  end

  // hold survives only if the lane never dropped during the window
  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      hold          <= '0;
      sync_status_o <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (win_start || !sync_in_i[i]) begin
          hold[i] <= sync_in_i[i];
        end
      end
      if (win_start) begin
        sync_status_o <= hold;
      end
    end
  end

endmodule

/* hdl/fmcadc5_sysref_gen.sv */
// fmcadc5 sysref generator: windowed external and internal sysref with one-shot service

`timescale 1ns/1ps

module fmcadc5_sysref_gen (
  input  logic                          rx_clk,
  input  logic                          up_rstn,
  input  fmcadc5_sync_pkg::sysref_cfg_t sysref_cfg_i,
  input  logic                          sysref_req_i,
  output logic                          sysref_ack_o,
  output logic                          sysref_ext_o,
  output logic                          sysref_int_o
);

  localparam int PW = fmcadc5_sync_pkg::PERIOD_W;

  logic [PW-1:0] period_cnt;
  logic          win_start;
  logic          req_pend;
  logic          enb_ext;
  logic          enb_int;
  logic          enb_ext_nxt;

  assign win_start = (period_cnt == '0);

  // free running window counter
  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  // pending request, dropped again at the next window start
  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      req_pend <= 1'b0;
    end else if (win_start || sysref_req_i) begin
      req_pend <= sysref_req_i;
    end
  end

  always_comb begin
    case (sysref_cfg_i.ext_mode)
      fmcadc5_sync_pkg::SYSREF_EXT_CONT:    enb_ext_nxt = 1'b1;
      fmcadc5_sync_pkg::SYSREF_EXT_ONESHOT: enb_ext_nxt = req_pend;
      default:                              enb_ext_nxt = 1'b0;
    endcase
  end

  // **********************************************************************
  // enables are only re-evaluated at window start
  // **********************************************************************

  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      enb_ext      <= 1'b0;
      enb_int      <= 1'b0;
      sysref_ack_o <= 1'b0;
    end else begin
      // ack marks the end of an enabled external window
      sysref_ack_o <= win_start & enb_ext;
      if (win_start) begin
        enb_ext <= enb_ext_nxt;
        enb_int <= (sysref_cfg_i.int_mode == fmcadc5_sync_pkg::SYSREF_INT_CONT);
      end
    end
  end

  // high in the upper half of each enabled window
  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      sysref_ext_o <= 1'b0;
      sysref_int_o <= 1'b0;
    end else begin
      sysref_ext_o <= period_cnt[PW-1] & enb_ext;
      sysref_int_o <= period_cnt[PW-1] & enb_int;
    end
  end

endmodule

/* hdl/fmcadc5_sync_regs.sv */
// fmcadc5 sync register file: control registers, scratch, timer and one-shot status

`timescale 1ns/1ps

module fmcadc5_sync_regs #(
  parameter logic [fmcadc5_sync_pkg::DATA_W-1:0] CORE_ID = '0
) (
  input  logic                                  rx_clk,
  input  logic                                  up_rstn,
  input  fmcadc5_sync_pkg::reg_req_t            reg_req_i,
  output fmcadc5_sync_pkg::reg_rsp_t            reg_rsp_o,
  output fmcadc5_sync_pkg::sync_cfg_t           sync_cfg_o,
  input  logic [1:0]                            sync_status_i,
  output fmcadc5_sync_pkg::sysref_cfg_t         sysref_cfg_o,
  output logic                                  sysref_req_o,
  input  logic                                  sysref_ack_i,
  output logic [fmcadc5_sync_pkg::VCAL_W-1:0]   vcal_cnt_o,
  output logic                                  vcal_en_o
);

  localparam int DW = fmcadc5_sync_pkg::DATA_W;
  localparam int VW = fmcadc5_sync_pkg::VCAL_W;

  logic          wr_scratch;
  logic          wr_timer;
  logic          wr_sync;
  logic          wr_sysref;
  logic          wr_req;
  logic          wr_vcal_cnt;
  logic          wr_vcal_en;
  logic [DW-1:0] scratch;
  logic [DW-1:0] timer;
  logic          sysref_status;
  logic [DW-1:0] rdata_nxt;

  // **********************************************************************
  // write decode
  // **********************************************************************

  assign wr_scratch  = reg_req_i.wr && (reg_req_i.addr == fmcadc5_sync_pkg::ADDR_SCRATCH);
  assign wr_timer    = reg_req_i.wr && (reg_req_i.addr == fmcadc5_sync_pkg::ADDR_TIMER);
  assign wr_sync     = reg_req_i.wr && (reg_req_i.addr == fmcadc5_sync_pkg::ADDR_SYNC_CTRL);
  assign wr_sysref   = reg_req_i.wr && (reg_req_i.addr == fmcadc5_sync_pkg::ADDR_SYSREF_CTRL);
  assign wr_req      = reg_req_i.wr && (reg_req_i.addr == fmcadc5_sync_pkg::ADDR_SYSREF_REQ);
  assign wr_vcal_cnt = reg_req_i.wr && (reg_req_i.addr == fmcadc5_sync_pkg::ADDR_VCAL_CNT);
  assign wr_vcal_en  = reg_req_i.wr && (reg_req_i.addr == fmcadc5_sync_pkg::ADDR_VCAL_EN);

  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      sync_cfg_o            <= '0;
      sysref_cfg_o.ext_mode <= fmcadc5_sync_pkg::SYSREF_EXT_CONT;
      sysref_cfg_o.int_mode <= fmcadc5_sync_pkg::SYSREF_INT_CONT;
      vcal_cnt_o            <= '0;
      vcal_en_o             <= 1'b0;
      scratch               <= '0;
      timer                 <= '0;
    end else begin
      if (wr_sync) begin
        sync_cfg_o <= fmcadc5_sync_pkg::sync_cfg_t'(reg_req_i.wdata[2:0]);
      end
      if (wr_sysref) begin
        sysref_cfg_o.ext_mode <= fmcadc5_sync_pkg::sysref_ext_mode_e'(reg_req_i.wdata[5:4]);
        sysref_cfg_o.int_mode <= fmcadc5_sync_pkg::sysref_int_mode_e'(reg_req_i.wdata[0]);
      end
      if (wr_vcal_cnt) begin
        vcal_cnt_o <= reg_req_i.wdata[VW-1:0];
      end
      if (wr_vcal_en) begin
        vcal_en_o <= reg_req_i.wdata[0];
      end
      if (wr_scratch) begin
        scratch <= reg_req_i.wdata;
      end
      // load on write, else count down and park at zero
      if (wr_timer) begin
        timer <= reg_req_i.wdata;
      end else if (timer != '0) begin
        timer <= timer - 1'b1;
      end
    end
  end

  // **********************************************************************
  // one-shot sysref request
  // **********************************************************************

  // a new request is taken only while idle
  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      sysref_status <= 1'b0;
      sysref_req_o  <= 1'b0;
    end else begin
      sysref_req_o <= 1'b0;
      if (sysref_status) begin
        if (sysref_ack_i) begin
          sysref_status <= 1'b0;
        end
      end else if (wr_req && reg_req_i.wdata[0]) begin
        sysref_status <= 1'b1;
        sysref_req_o  <= 1'b1;
      end
    end
  end

  // **********************************************************************
  // read mux
  // **********************************************************************

  always_comb begin
    rdata_nxt = '0;
    case (reg_req_i.addr)
      fmcadc5_sync_pkg::ADDR_VERSION:     rdata_nxt = fmcadc5_sync_pkg::CORE_VERSION;
      fmcadc5_sync_pkg::ADDR_ID:          rdata_nxt = CORE_ID;
      fmcadc5_sync_pkg::ADDR_SCRATCH:     rdata_nxt = scratch;
      fmcadc5_sync_pkg::ADDR_TIMER:       rdata_nxt = timer;
      fmcadc5_sync_pkg::ADDR_SYNC_CTRL:   rdata_nxt = {{(DW-3){1'b0}}, sync_cfg_o};
      fmcadc5_sync_pkg::ADDR_SYNC_STATUS: rdata_nxt = {{(DW-2){1'b0}}, sync_status_i};
      fmcadc5_sync_pkg::ADDR_SYSREF_CTRL: begin
        rdata_nxt = {{(DW-6){1'b0}}, sysref_cfg_o.ext_mode, 3'b000, sysref_cfg_o.int_mode};
      end
      fmcadc5_sync_pkg::ADDR_SYSREF_REQ:  rdata_nxt = {{(DW-1){1'b0}}, sysref_status};
      fmcadc5_sync_pkg::ADDR_VCAL_CNT:    rdata_nxt = {{(DW-VW){1'b0}}, vcal_cnt_o};
      fmcadc5_sync_pkg::ADDR_VCAL_EN:     rdata_nxt = {{(DW-1){1'b0}}, vcal_en_o};
      default:                            rdata_nxt = '0;
    endcase
  end

  // ack for both strobes, data only behind a read
  always_ff @(posedge rx_clk or negedge up_rstn) begin
    if (!up_rstn) begin
      reg_rsp_o <= '0;
    end else begin
      reg_rsp_o.ack   <= reg_req_i.wr | reg_req_i.rd;
      reg_rsp_o.rdata <= reg_req_i.rd ? rdata_nxt : '0;
    end
  end

endmodule

/* hdl/fmcadc5_sync_pkg.sv */
// fmcadc5 sync helper shared definitions: register map, widths, modes and port structs

package fmcadc5_sync_pkg;

  // **********************************************************************
  // register port widths and version
  // **********************************************************************

  localparam int ADDR_W = 14;
  localparam int DATA_W = 32;

  localparam logic [DATA_W-1:0] CORE_VERSION = 32'h0004_0063;

  // word addresses
  localparam logic [ADDR_W-1:0] ADDR_VERSION     = 14'h0000;
  localparam logic [ADDR_W-1:0] ADDR_ID          = 14'h0001;
  localparam logic [ADDR_W-1:0] ADDR_SCRATCH     = 14'h0002;
  localparam logic [ADDR_W-1:0] ADDR_TIMER       = 14'h0003;
  localparam logic [ADDR_W-1:0] ADDR_SYNC_CTRL   = 14'h0030;
  localparam logic [ADDR_W-1:0] ADDR_SYNC_STATUS = 14'h0031;
  localparam logic [ADDR_W-1:0] ADDR_SYSREF_CTRL = 14'h0040;
  localparam logic [ADDR_W-1:0] ADDR_SYSREF_REQ  = 14'h0041;
  localparam logic [ADDR_W-1:0] ADDR_VCAL_CNT    = 14'h0050;
  localparam logic [ADDR_W-1:0] ADDR_VCAL_EN     = 14'h0051;

  // **********************************************************************
  // timing generators
  // **********************************************************************

  // sysref and sync status window, 256 cycles
  localparam int PERIOD_W = 8;

  localparam int VCAL_W = 8;

  // regulator clock, 83 cycle frame, toggles on the last four counts
  localparam logic [7:0] PSYNC_LAST   = 8'h52;
  localparam logic [7:0] PSYNC_TOGGLE = 8'h4f;

  // **********************************************************************
  // modes and structs
  // **********************************************************************

  // value 3 falls through to off
  typedef enum logic [1:0] {
    SYSREF_EXT_CONT    = 2'd0,
    SYSREF_EXT_OFF     = 2'd1,
    SYSREF_EXT_ONESHOT = 2'd2
  } sysref_ext_mode_e;

  typedef enum logic {
    SYSREF_INT_CONT = 1'b0,
    SYSREF_INT_OFF  = 1'b1
  } sysref_int_mode_e;

  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } reg_rsp_t;

  // bit order matches the sync control register
  typedef struct packed {
    logic and_mode;
    logic disable_1;
    logic disable_0;
  } sync_cfg_t;

  typedef struct packed {
    sysref_ext_mode_e ext_mode;
    sysref_int_mode_e int_mode;
  } sysref_cfg_t;

endpackage
